//--- Makefile
# Verilator flow for the cache testbench.
SIM        = verilator
TOP        = cache_tb
FILELIST   = list.f
BUILD_DIR  = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result; a run that never reaches its report also fails.
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/cache_tb.sv
`timescale 1ns/1ps

module cache_tb
	import cache_pkg::*;
();

	localparam int INDEX_W     = 4;
	localparam int FIFO_DEPTH  = 4;
	localparam int TAG_W       = ADDR_W - INDEX_W;
	localparam int LINES       = 1 << INDEX_W;
	localparam int SEND_LIMIT  = 500;
	localparam int DRAIN_LIMIT = 5000;

	logic              clk = 1'b0;
	logic              rst;
	logic              req_valid;
	cpu_req_t          req;
	logic              req_ready;
	logic              rsp_valid;
	cpu_rsp_t          rsp;
	logic              mem_cs;
	mem_req_t          mem_req;
	logic              mem_ack;
	logic [DATA_W-1:0] mem_rdata;

	integer seed = 32'ha12f;

	// Behavioral memory behind the DUT, and the backing store of the reference model.
	logic [DATA_W-1:0] mem_model [1 << ADDR_W];
	logic [DATA_W-1:0] ref_mem [1 << ADDR_W];

	// Reference line state.
	logic [TAG_W-1:0]  ref_tag [LINES];
	logic [DATA_W-1:0] ref_data [LINES];
	logic [LINES-1:0]  ref_valid;
	logic [LINES-1:0]  ref_dirty;

	cpu_rsp_t          exp_q [$];
	int                checks = 0;
	int                errors = 0;
	int                tests = 0;
	int                err_mark = 0;
	int                mem_ops = 0;
	int                mem_writes = 0;
	logic [ADDR_W-1:0] last_wr_addr;
	logic [DATA_W-1:0] last_wr_data;
	bit                slow_mem;
	bit                saw_stall;

	cache_top #(
		.INDEX_W   (INDEX_W),
		.FIFO_DEPTH(FIFO_DEPTH)
	) UUT (
		.clk      (clk),
		.rst      (rst),
		.req_valid(req_valid),
		.req      (req),
		.req_ready(req_ready),
		.rsp_valid(rsp_valid),
		.rsp      (rsp),
		.mem_cs   (mem_cs),
		.mem_req  (mem_req),
		.mem_ack  (mem_ack),
		.mem_rdata(mem_rdata)
	);

	always #2 clk = ~clk;

	// Initial memory contents depend on every address bit.
	function automatic logic [DATA_W-1:0] init_word(input logic [ADDR_W-1:0] addr);
		return {addr ^ 16'hc3a5, ~addr};
	endfunction

	// Direct-mapped, write-back, write-allocate model of one access.
	function automatic cpu_rsp_t predict_response(input cpu_req_t r);
		cpu_rsp_t           e;
		logic [INDEX_W-1:0] idx;
		logic [TAG_W-1:0]   tg;
		idx     = r.addr[INDEX_W-1:0];
		tg      = r.addr[ADDR_W-1:INDEX_W];
		e.op    = r.op;
		e.hit   = ref_valid[idx] && (ref_tag[idx] == tg);
		e.rdata = '0;
		if (!e.hit)
		begin
			// A dirty victim returns to its old address before the fill.
			if (ref_valid[idx] && ref_dirty[idx])
				ref_mem[{ref_tag[idx], idx}] = ref_data[idx];
			ref_tag[idx]   = tg;
			ref_valid[idx] = 1'b1;
			ref_dirty[idx] = 1'b0;
			ref_data[idx]  = ref_mem[r.addr];
		end
		if (r.op == OP_WRITE)
		begin
			ref_data[idx]  = r.wdata;
			ref_dirty[idx] = 1'b1;
		end
		else
			e.rdata = ref_data[idx];
		return e;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %s: got 0x%h, expected 0x%h, controller in %s",
				name, got, exp, UUT.u_ctrl.state.name());
		end
	endtask

	task automatic abort_run(input string what);
		$display("Timeout while waiting for %s", what);
		$display("TB FAILED");
		$finish;
	endtask

	// Called at a rising edge; returns at the edge where the request transfers.
	task automatic send(input cache_op_e op, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata);
		cpu_req_t r;
		int       waited;
		r.op    = op;
		r.addr  = addr;
		r.wdata = (op == OP_WRITE) ? wdata : '0;
		exp_q.push_back(predict_response(r));
		req_valid <= 1'b1;
		req       <= r;
		waited = 0;
		do
		begin
			@(posedge clk);
			if (!req_ready)
			begin
				saw_stall = 1'b1;
				waited++;
				if (waited > SEND_LIMIT)
					abort_run("req_ready");
			end
		end
		while (!req_ready);
	endtask

	task automatic stop_requests();
		req_valid <= 1'b0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0)
		begin
			@(posedge clk);
			waited++;
			if (waited > DRAIN_LIMIT)
				abort_run("outstanding responses");
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - err_mark);
		err_mark = errors;
	endtask

	// Memory answers after 1 to 6 cycles with a one-cycle ack.
	initial
	begin
		int mem_wait;
		bit mem_busy;
		mem_ack   = 1'b0;
		mem_rdata = '0;
		mem_busy  = 1'b0;
		mem_wait  = 0;
		for (int a = 0; a < (1 << ADDR_W); a++)
			mem_model[a] = init_word(ADDR_W'(a));
		forever
		begin
			@(posedge clk);
			if (!rst || mem_ack)
			begin
				mem_ack <= 1'b0;
				mem_busy = 1'b0;
			end
			else if (mem_cs)
			begin
				if (!mem_busy)
				begin
					mem_busy = 1'b1;
					mem_wait = slow_mem ? 5 : int'($unsigned($random(seed)) % 6);
				end
				if (mem_wait == 0)
				begin
					mem_ack <= 1'b1;
					mem_ops++;
					if (mem_req.we)
					begin
						mem_model[mem_req.addr] = mem_req.wdata;
						mem_writes++;
						last_wr_addr = mem_req.addr;
						last_wr_data = mem_req.wdata;
					end
					else
						mem_rdata <= mem_model[mem_req.addr];
				end
				else
					mem_wait--;
			end
		end
	end

	// Response checker, in request order.
	initial
	begin
		cpu_rsp_t e;
		forever
		begin
			@(posedge clk);
			if (rst && rsp_valid)
			begin
				if (exp_q.size() == 0)
				begin
					errors++;
					$display("A response arrived with no request outstanding");
				end
				else
				begin
					e = exp_q.pop_front();
					check("rsp.op", 32'(rsp.op), 32'(e.op));
					check("rsp.hit", 32'(rsp.hit), 32'(e.hit));
					check("rsp.rdata", rsp.rdata, e.rdata);
				end
			end
		end
	end

	initial
	begin
		int                mark;
		logic [31:0]       rnd;
		logic [DATA_W-1:0] wval;
		rst       = 1'b0;
		req_valid = 1'b0;
		req       = '0;
		slow_mem  = 1'b0;
		saw_stall = 1'b0;
		ref_valid = '0;
		ref_dirty = '0;
		for (int a = 0; a < (1 << ADDR_W); a++)
			ref_mem[a] = init_word(ADDR_W'(a));

		repeat (8) @(posedge clk);
		check("req_ready", 32'(req_ready), 32'd0);
		repeat (8) @(posedge clk);
		rst <= 1'b1;
		@(posedge clk);
		check("rsp_valid", 32'(rsp_valid), 32'd0);
		check("mem_cs", 32'(mem_cs), 32'd0);
		send(OP_READ, 16'h0123, '0);
		send(OP_READ, 16'h0456, '0);
		stop_requests();
		drain();
		end_test("reset state and first miss");

		mark = mem_ops;
		send(OP_READ, 16'h0123, '0);
		send(OP_READ, 16'h0456, '0);
		stop_requests();
		drain();
		check("mem_cs transactions", 32'(mem_ops - mark), 32'd0);
		end_test("read hit");

		mark = mem_writes;
		wval = $random(seed);
		send(OP_WRITE, 16'h0123, wval);
		send(OP_READ, 16'h0123, '0);
		stop_requests();
		drain();
		check("mem write count", 32'(mem_writes - mark), 32'd0);
		end_test("write hit then read");

		// Same index 5, two tags.
		mark = mem_writes;
		wval = $random(seed);
		send(OP_WRITE, 16'h0305, wval);
		send(OP_READ, 16'h0705, '0);
		stop_requests();
		drain();
		check("mem write count", 32'(mem_writes - mark), 32'd1);
		check("mem_req.addr", 32'(last_wr_addr), 32'h0000_0305);
		check("mem_req.wdata", last_wr_data, wval);
		send(OP_READ, 16'h0305, '0);
		stop_requests();
		drain();
		end_test("dirty eviction");

		slow_mem  = 1'b1;
		saw_stall = 1'b0;
		for (int i = 0; i < 2 * FIFO_DEPTH + 2; i++)
		begin
			rnd = $random(seed);
			send(i[0] ? OP_WRITE : OP_READ, 16'h0a00 | 16'(i), rnd);
		end
		stop_requests();
		drain();
		slow_mem = 1'b0;
		check("req_ready stall", 32'(saw_stall), 32'd1);
		end_test("back-pressure");

		// Four tags over four lines, with an idle cycle now and then.
		for (int n = 0; n < 200; n++)
		begin
			rnd  = $random(seed);
			wval = $random(seed);
			send(rnd[8] ? OP_WRITE : OP_READ, {10'h000, rnd[5:4], 2'b00, rnd[1:0]}, wval);
			if (rnd[12:11] == 2'b00)
			begin
				stop_requests();
				@(posedge clk);
			end
		end
		stop_requests();
		drain();
		end_test("random traffic");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- list.f
source/cache_pkg.sv
source/cache_req_fifo.sv
source/cache_array.sv
source/cache_ctrl.sv
source/cache_top.sv
dv/cache_tb.sv

//--- source/cache_array.sv
`timescale 1ns/1ps

module cache_array
	import cache_pkg::*;
#(
	parameter int INDEX_W = 4
)
(
	input  logic                        clk,
	input  logic                        rst,

	// Lookup of the line selected by the address index.
	input  logic [ADDR_W-1:0]           lookup_addr,
	output logic                        hit,
	output logic                        victim_dirty,
	output logic [ADDR_W-INDEX_W-1:0]   victim_tag,
	output logic [DATA_W-1:0]           rd_data,

	// Line update at the same index.
	input  logic                        wr_en,
	input  logic [ADDR_W-INDEX_W-1:0]   wr_tag,
	input  logic [DATA_W-1:0]           wr_data,
	input  logic                        wr_dirty
);

	localparam int TAG_W = ADDR_W - INDEX_W;
	localparam int LINES = 1 << INDEX_W;

	logic [TAG_W-1:0]   tag_mem  [LINES];
	logic [DATA_W-1:0]  data_mem [LINES];
	logic [LINES-1:0]   valid;
	logic [LINES-1:0]   dirty;
	logic [INDEX_W-1:0] index;
	logic [TAG_W-1:0]   tag;

	assign index = lookup_addr[INDEX_W-1:0];
	assign tag   = lookup_addr[ADDR_W-1:INDEX_W];

	// Invalid lines never hit, whatever their stale tag holds.
	assign hit          = valid[index] && (tag_mem[index] == tag);
	assign victim_dirty = valid[index] && dirty[index];
	assign victim_tag   = tag_mem[index];
	assign rd_data      = data_mem[index];

	// Line state bits.
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			valid <= '0;
			dirty <= '0;
		end
		else if (wr_en)
		begin
			valid[index] <= 1'b1;
			dirty[index] <= wr_dirty;
		end
	end

	// Tag and data storage.
	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			tag_mem[index]  <= wr_tag;
			data_mem[index] <= wr_data;
		end
	end

	a_wr_en_known: assert property (@(posedge clk) disable iff (!rst)
		!$isunknown(wr_en));

endmodule

//--- source/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl
	import cache_pkg::*;
#(
	parameter int INDEX_W = 4
)
(
	input  logic                        clk,
	input  logic                        rst,

	// Request FIFO.
	input  logic                        deq_valid,
	input  cpu_req_t                    deq_req,
	output logic                        deq_ready,

	// Tag and data array.
	input  logic                        hit,
	input  logic                        victim_dirty,
	input  logic [ADDR_W-INDEX_W-1:0]   victim_tag,
	input  logic [DATA_W-1:0]           rd_data,
	output logic [ADDR_W-1:0]           lookup_addr,
	output logic                        wr_en,
	output logic [ADDR_W-INDEX_W-1:0]   wr_tag,
	output logic [DATA_W-1:0]           wr_data,
	output logic                        wr_dirty,

	// External memory.
	output logic                        mem_cs,
	output mem_req_t                    mem_req,
	input  logic                        mem_ack,
	input  logic [DATA_W-1:0]           mem_rdata,

	// CPU response.
	output logic                        rsp_valid,
	output cpu_rsp_t                    rsp
);

	localparam int TAG_W = ADDR_W - INDEX_W;

	ctrl_state_e        state;
	ctrl_state_e        next_state;
	cpu_req_t           cur_req;
	logic [DATA_W-1:0]  fill_data;
	logic [INDEX_W-1:0] cur_index;
	logic [TAG_W-1:0]   cur_tag;
	logic               cur_write;

	assign cur_index   = cur_req.addr[INDEX_W-1:0];
	assign cur_tag     = cur_req.addr[ADDR_W-1:INDEX_W];
	assign cur_write   = (cur_req.op == OP_WRITE);
	assign lookup_addr = cur_req.addr;
	assign deq_ready   = (state == ST_IDLE) && deq_valid;
	assign wr_tag      = cur_tag;

	always_comb
	begin
		next_state = state;
		case (state)
			ST_IDLE:
				if (deq_valid)
					next_state = ST_LOOKUP;
			ST_LOOKUP:
				if (hit)
					next_state = ST_RESPOND;
				else if (victim_dirty)
					next_state = ST_WRITE_BACK;
				else
					next_state = ST_FILL;
			ST_WRITE_BACK:
				next_state = ST_WRITE_BACK_MEM;
			ST_WRITE_BACK_MEM:
				if (mem_ack)
					next_state = ST_FILL;
			ST_FILL:
				next_state = ST_FILL_MEM;
			ST_FILL_MEM:
				if (mem_ack)
					next_state = ST_FILL_DATA;
			ST_FILL_DATA:
				next_state = ST_RESPOND;
			default:
				next_state = ST_IDLE;
		endcase
	end

	// Array writes: write hits in lookup, line fills after memory returns.
	always_comb
	begin
		wr_en    = 1'b0;
		wr_data  = cur_req.wdata;
		wr_dirty = 1'b1;
		if (state == ST_LOOKUP)
			wr_en = hit && cur_write;
		else if (state == ST_FILL_DATA)
		begin
			wr_en    = 1'b1;
			wr_data  = cur_write ? cur_req.wdata : fill_data;
			wr_dirty = cur_write;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state     <= ST_IDLE;
			mem_cs    <= 1'b0;
			rsp_valid <= 1'b0;
		end
		else
		begin
			state     <= next_state;
			// Select is held through both wait states and drops after the ack.
			mem_cs    <= (next_state == ST_WRITE_BACK_MEM) || (next_state == ST_FILL_MEM);
			rsp_valid <= (next_state == ST_RESPOND);
		end
	end

	always_ff @(posedge clk)
	begin
		if (deq_ready)
			cur_req <= deq_req;
		case (state)
			ST_LOOKUP:
			begin
				rsp.op    <= cur_req.op;
				rsp.hit   <= hit;
				rsp.rdata <= (hit && !cur_write) ? rd_data : '0;
			end
			ST_WRITE_BACK:
			begin
				// Victim word goes back to the address it came from.
				mem_req.we    <= 1'b1;
				mem_req.addr  <= {victim_tag, cur_index};
				mem_req.wdata <= rd_data;
			end
			ST_FILL:
			begin
				mem_req.we    <= 1'b0;
				mem_req.addr  <= cur_req.addr;
				mem_req.wdata <= '0;
			end
			ST_FILL_MEM:
				if (mem_ack)
					fill_data <= mem_rdata;
			ST_FILL_DATA:
				rsp.rdata <= cur_write ? '0 : fill_data;
			default:
				;
		endcase
	end

	a_mem_hold: assert property (@(posedge clk) disable iff (!rst)
		mem_cs && !mem_ack |=> mem_cs && $stable(mem_req));

	a_mem_release: assert property (@(posedge clk) disable iff (!rst)
		mem_cs && mem_ack |=> !mem_cs);

	a_rsp_state: assert property (@(posedge clk) disable iff (!rst)
		rsp_valid |-> (state == ST_RESPOND));

endmodule

//--- source/cache_pkg.sv
package cache_pkg;

	// Fixed bus widths, shared by every packed struct below.
	localparam int ADDR_W = 16;
	localparam int DATA_W = 32;

	// CPU operation on one word.
	typedef enum logic
	{
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} cache_op_e;

	// Controller states.
	typedef enum logic [3:0]
	{
		ST_IDLE           = 4'd0,
		ST_LOOKUP         = 4'd1,
		ST_WRITE_BACK     = 4'd2,
		ST_WRITE_BACK_MEM = 4'd3,
		ST_FILL           = 4'd4,
		ST_FILL_MEM       = 4'd5,
		ST_FILL_DATA      = 4'd6,
		ST_RESPOND        = 4'd7
	} ctrl_state_e;

	// Request from the CPU side.
	typedef struct packed
	{
		cache_op_e         op;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} cpu_req_t;

	// Response to the CPU side; rdata is zero for writes.
	typedef struct packed
	{
		cache_op_e         op;
		logic              hit;
		logic [DATA_W-1:0] rdata;
	} cpu_rsp_t;

	// Request toward external memory.
	typedef struct packed
	{
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} mem_req_t;

endpackage

//--- source/cache_req_fifo.sv
`timescale 1ns/1ps

module cache_req_fifo
	import cache_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
)
(
	input  logic     clk,
	input  logic     rst,

	// CPU request port.
	input  logic     req_valid,
	input  cpu_req_t req,
	output logic     req_ready,

	// Controller side.
	output logic     deq_valid,
	output cpu_req_t deq_req,
	input  logic     deq_ready
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	cpu_req_t         slots [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_nxt;
	logic             push;
	logic             pop;

	// Wrap a pointer at the buffer depth.
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign push      = req_valid && req_ready;
	assign pop       = deq_ready && deq_valid;
	assign deq_valid = (count != '0);
	assign deq_req   = slots[rd_ptr];

	always_comb
	begin
		count_nxt = count;
		if (push && !pop)
			count_nxt = count + 1'b1;
		else if (pop && !push)
			count_nxt = count - 1'b1;
	end

	// Ready is registered from the next occupancy, so it stays low in reset.
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			req_ready <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			count     <= count_nxt;
			req_ready <= (count_nxt != CNT_W'(FIFO_DEPTH));
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			slots[wr_ptr] <= req;
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
		push |-> (count < CNT_W'(FIFO_DEPTH)));

	// The controller must only pop while a request is waiting.
	a_no_empty_pop: assert property (@(posedge clk) disable iff (!rst)
		deq_ready |-> (count != '0));

endmodule

//--- source/cache_top.sv
`timescale 1ns/1ps

module cache_top
	import cache_pkg::*;
#(
	parameter int INDEX_W    = 4,
	parameter int FIFO_DEPTH = 4
)
(
	input  logic              clk,
	input  logic              rst,

	// CPU request port.
	input  logic              req_valid,
	input  cpu_req_t          req,
	output logic              req_ready,

	// CPU response port.
	output logic              rsp_valid,
	output cpu_rsp_t          rsp,

	// External memory port.
	output logic              mem_cs,
	output mem_req_t          mem_req,
	input  logic              mem_ack,
	input  logic [DATA_W-1:0] mem_rdata
);

	localparam int TAG_W = ADDR_W - INDEX_W;

	logic              deq_valid;
	logic              deq_ready;
	cpu_req_t          deq_req;
	logic [ADDR_W-1:0] lookup_addr;
	logic              hit;
	logic              victim_dirty;
	logic [TAG_W-1:0]  victim_tag;
	logic [DATA_W-1:0] rd_data;
	logic              wr_en;
	logic [TAG_W-1:0]  wr_tag;
	logic [DATA_W-1:0] wr_data;
	logic              wr_dirty;

	cache_req_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk      (clk),
		.rst      (rst),
		.req_valid(req_valid),
		.req      (req),
		.req_ready(req_ready),
		.deq_valid(deq_valid),
		.deq_req  (deq_req),
		.deq_ready(deq_ready)
	);

	cache_array #(
		.INDEX_W(INDEX_W)
	) u_array (
		.clk         (clk),
		.rst         (rst),
		.lookup_addr (lookup_addr),
		.hit         (hit),
		.victim_dirty(victim_dirty),
		.victim_tag  (victim_tag),
		.rd_data     (rd_data),
		.wr_en       (wr_en),
		.wr_tag      (wr_tag),
		.wr_data     (wr_data),
		.wr_dirty    (wr_dirty)
	);

	cache_ctrl #(
		.INDEX_W(INDEX_W)
	) u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.deq_valid   (deq_valid),
		.deq_req     (deq_req),
		.deq_ready   (deq_ready),
		.hit         (hit),
		.victim_dirty(victim_dirty),
		.victim_tag  (victim_tag),
		.rd_data     (rd_data),
		.lookup_addr (lookup_addr),
		.wr_en       (wr_en),
		.wr_tag      (wr_tag),
		.wr_data     (wr_data),
		.wr_dirty    (wr_dirty),
		.mem_cs      (mem_cs),
		.mem_req     (mem_req),
		.mem_ack     (mem_ack),
		.mem_rdata   (mem_rdata),
		.rsp_valid   (rsp_valid),
		.rsp         (rsp)
	);

endmodule
